/* sim.f */
ooo_pkg.sv
reservation_station.sv
exec_unit.sv
issue_core_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import ooo_pkg::*;
();

    localparam int NUM_CDB     = NUM_CDB_DEF + 1;  // Two external ports, so tags can collide
    localparam int NUM_EXT     = NUM_CDB - 1;
    localparam int NUM_INSTR   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTR * 40;
    localparam int SEED        = 7439;

    logic             clk = 1'b0;
    logic             rst_n_i;
    logic             flush_i;
    logic             cache_stall_i;
    instruction_t     disp_entry_i;
    logic             disp_we_i;
    logic             disp_rdy_o;
    writeback_t       cdb_ext_i [NUM_EXT];
    writeback_t       wb_o;
    logic             exp_push;
    writeback_t       exp_wb;
    int               value_errs;
    int               pending;
    int               other_errs;
    int               cycle_cnt = 0;
    logic [TAG_W-1:0] next_tag;     // External tags live in 32..63

    always #10 clk = ~clk;

    issue_core_top #(
        .NUM_CDB (NUM_CDB)
    ) dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .cache_stall_i (cache_stall_i),
        .disp_entry_i  (disp_entry_i),
        .disp_we_i     (disp_we_i),
        .disp_rdy_o    (disp_rdy_o),
        .cdb_ext_i     (cdb_ext_i),
        .wb_o          (wb_o)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .disp_rdy_i (disp_rdy_o),
        .wb_i       (wb_o),
        .exp_push_i (exp_push),
        .exp_wb_i   (exp_wb),
        .err_cnt_o  (value_errs),
        .pending_o  (pending)
    );

    function automatic logic [XLEN-1:0] model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   sa;
        logic [XLEN-1:0]   sb;
        sa   = a ^ {1'b1, {(XLEN-1){1'b0}}};  // Sign flip turns signed into unsigned order
        sb   = b ^ {1'b1, {(XLEN-1){1'b0}}};
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + XLEN'(1);
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return (sa < sb) ? XLEN'(1) : XLEN'(0);
            ALU_SLTU: return (a < b) ? XLEN'(1) : XLEN'(0);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_MUL:  return prod[XLEN-1:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_branch(input br_op_e op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        logic lt_s;
        lt_s = (a ^ {1'b1, {(XLEN-1){1'b0}}}) < (b ^ {1'b1, {(XLEN-1){1'b0}}});
        case (op)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return lt_s;
            BR_GE:   return !lt_s;
            BR_LTU:  return a < b;
            BR_GEU:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // Small values now and then so compares hit equal and near cases
    function automatic logic [XLEN-1:0] rand_data();
        if ($urandom_range(0, 3) == 0) begin
            return XLEN'($urandom_range(0, 3));
        end
        return $urandom;
    endfunction

    task automatic tick();
        @(posedge clk);
        exp_push <= 1'b0;
        flush_i  <= 1'b0;
        for (int p = 0; p < NUM_EXT; p++) begin
            cdb_ext_i[p] <= '0;   // Each result valid for one cycle only
        end
    endtask

    task automatic drive_cdb(input int port, input logic [TAG_W-1:0] tag,
                             input logic [XLEN-1:0] value);
        writeback_t wb;
        wb          = '0;
        wb.is_valid = 1'b1;
        wb.dest_tag = tag;
        wb.result   = value;
        cdb_ext_i[port] <= wb;
    endtask

    // Sometimes a decoy on a lower port carries the same tag
    task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] value);
        if (NUM_EXT > 1 && $urandom_range(0, 2) == 0) begin
            drive_cdb(NUM_EXT - 1, tag, value);
            drive_cdb($urandom_range(0, NUM_EXT - 2), tag, ~value);
        end else begin
            drive_cdb($urandom_range(0, NUM_EXT - 1), tag, value);
        end
    endtask

    task automatic dispatch_one(input int n);
        instruction_t    ins;
        operand_t        ops [4];
        logic [XLEN-1:0] val [4];
        int              dly [4];
        int              stall_left;
        bit              zero_used;
        bit              taken;
        bit              stall_low;
        bit              early;
        writeback_t      exp;
        zero_used = 1'b0;
        taken     = 1'b0;
        stall_low = 1'b0;
        early     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            val[i]      = rand_data();
            ops[i]      = '0;
            ops[i].data = val[i];
            dly[i]      = -1;
            if ($urandom_range(0, 2) == 0) begin
                ops[i].is_renamed = 1'b1;
                ops[i].tag        = next_tag;
                ops[i].data       = $urandom;  // Stale data, must be replaced
                next_tag          = (next_tag == '1) ? TAG_W'(32) : next_tag + 1'b1;
                dly[i]            = $urandom_range(0, 4);
                if (dly[i] == 0) begin
                    if (zero_used) begin
                        dly[i] = 1;
                    end
                    zero_used = 1'b1;
                end
            end
        end
        if ($urandom_range(0, 3) == 0) begin
            val[3] = val[2];
            if (!ops[3].is_renamed) begin
                ops[3].data = val[3];
            end
        end

        ins          = '0;
        ins.is_valid = 1'b1;
        ins.pc       = 32'h0000_1000 + XLEN'(n * 4);
        ins.dest_tag = TAG_W'($urandom_range(0, 31));
        ins.has_rd   = ($urandom_range(0, 3) != 0);
        ins.uop_0    = alu_op_e'(4'($urandom_range(0, 9)));
        ins.uop_1    = br_op_e'(3'($urandom_range(0, 6)));
        ins.src_0_a  = ops[0];
        ins.src_0_b  = ops[1];
        ins.src_1_a  = ops[2];
        ins.src_1_b  = ops[3];

        exp          = '0;
        exp.is_valid = 1'b1;
        exp.dest_tag = ins.dest_tag;
        exp.result   = model_alu(ins.uop_0, val[0], val[1]);
        exp.br_taken = model_branch(ins.uop_1, val[2], val[3]);
        exp.pc       = ins.pc;

        // Stall held until the slot is known to be free
        stall_left = $urandom_range(0, 2);
        tick();
        disp_entry_i  <= ins;
        disp_we_i     <= 1'b1;
        cache_stall_i <= 1'b1;
        while (!taken) begin
            tick();
            if (stall_low && disp_rdy_o) begin
                // Slot freed while the stall was low, taken at this edge
                for (int i = 0; i < 4; i++) begin
                    if (dly[i] == 0) begin
                        dly[i] = 1;
                    end
                end
                early = 1'b1;
                taken = 1'b1;
            end else if (disp_rdy_o && stall_left == 0) begin
                cache_stall_i <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                    if (dly[i] == 0) begin
                        broadcast(ops[i].tag, val[i]);  // Lands in the accept cycle
                    end
                end
                taken = 1'b1;
            end else begin
                if (stall_left > 0) begin
                    stall_left--;
                end
                // Stall dropped now and then while the slot is busy
                stall_low     = !disp_rdy_o && ($urandom_range(0, 1) == 0);
                cache_stall_i <= !stall_low;
            end
        end
        if (!early) begin
            tick();
        end
        disp_we_i <= 1'b0;
        exp_push  <= 1'b1;
        exp_wb    <= exp;
        for (int i = 0; i < 4; i++) begin
            if (dly[i] > 0) begin
                repeat (dly[i]) tick();
                broadcast(ops[i].tag, val[i]);
            end
        end
        tick();
    endtask

    task automatic end_run(input bit timed_out);
        if (timed_out) begin
            other_errs++;
        end
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            end_run(1'b1);
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        cache_stall_i = 1'b0;
        disp_we_i     = 1'b0;
        disp_entry_i  = '0;
        exp_push      = 1'b0;
        exp_wb        = '0;
        other_errs    = 0;
        next_tag      = TAG_W'(32);
        for (int p = 0; p < NUM_EXT; p++) begin
            cdb_ext_i[p] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int n = 0; n < NUM_INSTR; n++) begin
            dispatch_one(n);
            if ($urandom_range(0, 24) == 0) begin
                tick();
                flush_i <= 1'b1;
                tick();
            end
        end

        // Drain what is still in the station or execute unit
        while (pending != 0) begin
            tick();
        end
        repeat (4) tick();
        end_run(1'b0);
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import ooo_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       disp_rdy_i,
    input  writeback_t wb_i,

    // Expected writebacks in dispatch order
    input  logic       exp_push_i,
    input  writeback_t exp_wb_i,

    output int         err_cnt_o,
    output int         pending_o
);

    writeback_t exp_q [$];   // In-order model of results still to come
    logic       after_reset;
    logic       after_flush;
    int         wb_seen;

    task automatic check_field(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] got);
        if (exp !== got) begin
            $display("Fail %s: expected %h, got %h (writeback %0d)", name, exp, got, wb_seen);
            err_cnt_o++;
        end
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        writeback_t exp;
        if (!rst_n_i) begin
            exp_q.delete();
            err_cnt_o   = 0;
            pending_o   = 0;
            wb_seen     = 0;
            after_reset <= 1'b1;
            after_flush <= 1'b0;
        end else begin
            // Station must be empty right after reset or flush
            if ((after_reset || after_flush) && !disp_rdy_i) begin
                $display("Dispatch was not ready in the cycle after reset or flush");
                err_cnt_o++;
            end
            after_reset <= 1'b0;

            if (wb_i.is_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Writeback with tag %h appeared while no instruction was pending",
                             wb_i.dest_tag);
                    err_cnt_o++;
                end else begin
                    exp = exp_q.pop_front();
                    check_field("wb_o.dest_tag", XLEN'(exp.dest_tag), XLEN'(wb_i.dest_tag));
                    check_field("wb_o.result", exp.result, wb_i.result);
                    check_field("wb_o.br_taken", XLEN'(exp.br_taken), XLEN'(wb_i.br_taken));
                    check_field("wb_o.pc", exp.pc, wb_i.pc);
                    wb_seen++;
                end
            end

            if (exp_push_i) begin
                exp_q.push_back(exp_wb_i);
            end

            // Held and in-flight work is dropped, a result already shown counts
            if (flush_i) begin
                exp_q.delete();
            end
            after_flush <= flush_i;
            pending_o = exp_q.size();
        end
    end

endmodule

/* issue_core_top.sv */
`timescale 1ns/1ps

module issue_core_top
    import ooo_pkg::*;
#(
    parameter int NUM_CDB = NUM_CDB_DEF
) (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         cache_stall_i,

    input  instruction_t disp_entry_i,
    input  logic         disp_we_i,
    output logic         disp_rdy_o,

    // Results from the other units, CDB ports 1 and up
    input  writeback_t   cdb_ext_i [NUM_CDB-1],

    output writeback_t   wb_o
);

    writeback_t   cdb [NUM_CDB];
    instruction_t issue_pkt;
    logic         issue_vld;
    logic         exec_rdy;

    // Port 0 belongs to the execute unit
    assign cdb[0] = wb_o;

    for (genvar i = 1; i < NUM_CDB; i++) begin : g_cdb_ext
        assign cdb[i] = cdb_ext_i[i-1];
    end

    reservation_station #(
        .NUM_CDB (NUM_CDB)
    ) u_rs (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .cache_stall_i (cache_stall_i),
        .disp_entry_i  (disp_entry_i),
        .disp_we_i     (disp_we_i),
        .disp_rdy_o    (disp_rdy_o),
        .issue_pkt_o   (issue_pkt),
        .issue_vld_o   (issue_vld),
        .exec_rdy_i    (exec_rdy),
        .cdb_i         (cdb)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue_pkt_i (issue_pkt),
        .issue_vld_i (issue_vld),
        .exec_rdy_o  (exec_rdy),
        .wb_o        (wb_o)
    );

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import ooo_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  instruction_t issue_pkt_i,
    input  logic         issue_vld_i,
    output logic         exec_rdy_o,
    output writeback_t   wb_o
);

    localparam int CHUNK = XLEN / MUL_CYCLES;  // Multiplier bits per step
    localparam int CNT_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

    typedef enum logic {
        EX_IDLE,
        EX_MUL
    } ex_state_e;

    ex_state_e        state_q;
    logic [CNT_W-1:0] mul_cnt_q;
    logic             issue_fire;
    logic             is_mul;
    logic             mul_last;
    logic [XLEN-1:0]  alu_res;
    logic             br_res;

    // Multiply datapath
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [XLEN-1:0]  acc_q;
    logic [XLEN-1:0]  mul_partial;
    logic [XLEN-1:0]  acc_sum;
    logic [TAG_W-1:0] mul_tag_q;
    logic [XLEN-1:0]  mul_pc_q;
    logic             mul_br_q;

    // Result register
    logic             wb_vld_q;
    logic [TAG_W-1:0] wb_tag_q;
    logic [XLEN-1:0]  wb_res_q;
    logic             wb_br_q;
    logic [XLEN-1:0]  wb_pc_q;

    function automatic logic [XLEN-1:0] alu_eval(alu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return '0;  // MUL goes through the iterative path
        endcase
    endfunction

    function automatic logic br_eval(br_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            BR_GEU:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    assign exec_rdy_o = (state_q == EX_IDLE);  // Low for the whole multiply
    assign issue_fire = issue_vld_i && exec_rdy_o;
    assign is_mul     = (issue_pkt_i.uop_0 == ALU_MUL);

    assign alu_res = alu_eval(issue_pkt_i.uop_0, issue_pkt_i.src_0_a.data,
                              issue_pkt_i.src_0_b.data);
    assign br_res  = br_eval(issue_pkt_i.uop_1, issue_pkt_i.src_1_a.data,
                             issue_pkt_i.src_1_b.data);

    // One CHUNK-wide slice of the multiplier per cycle
    assign mul_partial = mcand_q * {{(XLEN-CHUNK){1'b0}}, mplier_q[CHUNK-1:0]};
    assign acc_sum     = acc_q + mul_partial;
    assign mul_last    = (state_q == EX_MUL) && (mul_cnt_q == CNT_W'(MUL_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= EX_IDLE;
            mul_cnt_q <= '0;
            wb_vld_q  <= 1'b0;
        end else if (flush_i) begin
            state_q  <= EX_IDLE;
            wb_vld_q <= 1'b0;
        end else begin
            wb_vld_q <= (issue_fire && !is_mul) || mul_last;  // Shown for one cycle
            case (state_q)
                EX_IDLE: begin
                    if (issue_fire && is_mul) begin
                        state_q   <= EX_MUL;
                        mul_cnt_q <= '0;
                    end
                end
                EX_MUL: begin
                    if (mul_last) begin
                        state_q <= EX_IDLE;
                    end else begin
                        mul_cnt_q <= mul_cnt_q + 1'b1;
                    end
                end
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire && is_mul) begin
            mcand_q   <= issue_pkt_i.src_0_a.data;
            mplier_q  <= issue_pkt_i.src_0_b.data;
            acc_q     <= '0;
            mul_tag_q <= issue_pkt_i.dest_tag;
            mul_pc_q  <= issue_pkt_i.pc;
            mul_br_q  <= br_res;
        end else if (state_q == EX_MUL) begin
            mcand_q  <= mcand_q << CHUNK;
            mplier_q <= mplier_q >> CHUNK;
            acc_q    <= acc_sum;
        end

        // Branches without rd still get a writeback
        if (issue_fire && !is_mul) begin
            wb_tag_q <= issue_pkt_i.dest_tag;
            wb_res_q <= alu_res;
            wb_br_q  <= br_res;
            wb_pc_q  <= issue_pkt_i.pc;
        end else if (mul_last) begin
            wb_tag_q <= mul_tag_q;
            wb_res_q <= acc_sum;  // Last slice folded in here
            wb_br_q  <= mul_br_q;
            wb_pc_q  <= mul_pc_q;
        end
    end

    always_comb begin
        wb_o.is_valid = wb_vld_q;
        wb_o.dest_tag = wb_tag_q;
        wb_o.result   = wb_res_q;
        wb_o.br_taken = wb_br_q;
        wb_o.pc       = wb_pc_q;
    end

endmodule

/* reservation_station.sv */
`timescale 1ns/1ps

module reservation_station
    import ooo_pkg::*;
#(
    parameter int NUM_CDB = NUM_CDB_DEF
) (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         cache_stall_i,

    // Dispatch side
    input  instruction_t disp_entry_i,
    input  logic         disp_we_i,
    output logic         disp_rdy_o,

    // Execute side
    output instruction_t issue_pkt_o,
    output logic         issue_vld_o,
    input  logic         exec_rdy_i,

    // Result bus
    input  writeback_t   cdb_i [NUM_CDB]
);

    logic         slot_vld_q;   // Slot holds an instruction
    instruction_t entry_q;      // Held instruction payload
    instruction_t entry_d;
    instruction_t held_woken;   // Held entry after CDB wakeup
    instruction_t disp_woken;   // Incoming entry after CDB capture
    logic         ops_ready;
    logic         issue_fire;
    logic         accept;

    function automatic logic tag_hit(operand_t op, writeback_t wb);
        return op.is_renamed && wb.is_valid && (wb.dest_tag == op.tag);
    endfunction

    // Ascending scan so the highest matching port is the last to write
    function automatic operand_t wake_operand(operand_t op, writeback_t cdb [NUM_CDB]);
        operand_t res;
        res = op;
        for (int i = 0; i < NUM_CDB; i++) begin
            if (tag_hit(op, cdb[i])) begin
                res.data       = cdb[i].result;
                res.is_renamed = 1'b0;
            end
        end
        return res;
    endfunction

    // Wakeup of the held entry
    always_comb begin
        held_woken         = entry_q;
        held_woken.src_0_a = wake_operand(entry_q.src_0_a, cdb_i);
        held_woken.src_0_b = wake_operand(entry_q.src_0_b, cdb_i);
        held_woken.src_1_a = wake_operand(entry_q.src_1_a, cdb_i);
        held_woken.src_1_b = wake_operand(entry_q.src_1_b, cdb_i);
    end

    // Capture for a result that lands in the dispatch cycle
    always_comb begin
        disp_woken         = disp_entry_i;
        disp_woken.src_0_a = wake_operand(disp_entry_i.src_0_a, cdb_i);
        disp_woken.src_0_b = wake_operand(disp_entry_i.src_0_b, cdb_i);
        disp_woken.src_1_a = wake_operand(disp_entry_i.src_1_a, cdb_i);
        disp_woken.src_1_b = wake_operand(disp_entry_i.src_1_b, cdb_i);
    end

    // Readiness looks at the held register only
    assign ops_ready = !entry_q.src_0_a.is_renamed &&
                       !entry_q.src_0_b.is_renamed &&
                       !entry_q.src_1_a.is_renamed &&
                       !entry_q.src_1_b.is_renamed;

    assign issue_vld_o = slot_vld_q && ops_ready;
    assign issue_fire  = issue_vld_o && exec_rdy_i;

    // Empty slot, or the held entry leaves this cycle
    assign disp_rdy_o = !slot_vld_q || issue_fire;

    assign accept = disp_we_i && disp_entry_i.is_valid && !cache_stall_i && disp_rdy_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_vld_q <= 1'b0;
        end else if (flush_i) begin
            slot_vld_q <= 1'b0;
        end else if (accept) begin
            slot_vld_q <= 1'b1;
        end else if (issue_fire) begin
            slot_vld_q <= 1'b0;
        end
    end

    // New entry wins over wakeup of the one leaving
    assign entry_d = accept ? disp_woken : held_woken;

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    always_comb begin
        issue_pkt_o          = entry_q;
        issue_pkt_o.is_valid = slot_vld_q;
    end

endmodule

/* ooo_pkg.sv */
package ooo_pkg;

    // Datapath and tag widths
    localparam int XLEN        = 32;
    localparam int TAG_W       = 6;
    localparam int NUM_CDB_DEF = 2;   // Exec port plus one external
    localparam int MUL_CYCLES  = 4;   // Issue to writeback for MUL

    // Operation on operand pair 0
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_MUL  = 4'd9
    } alu_op_e;

    // Comparison on operand pair 1
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_op_e;

    // Source operand whose data is only meaningful once is_renamed drops
    typedef struct packed {
        logic             is_renamed;
        logic [TAG_W-1:0] tag;        // Producer tag while renamed
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        logic             is_valid;
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] dest_tag;
        logic             has_rd;
        alu_op_e          uop_0;
        br_op_e           uop_1;
        operand_t         src_0_a;    // ALU operands
        operand_t         src_0_b;
        operand_t         src_1_a;    // Branch compare operands
        operand_t         src_1_b;
    } instruction_t;

    // One result on one CDB port
    typedef struct packed {
        logic             is_valid;
        logic [TAG_W-1:0] dest_tag;
        logic [XLEN-1:0]  result;
        logic             br_taken;
        logic [XLEN-1:0]  pc;
    } writeback_t;

endpackage
